//--- all.f
hw/cachePkg.sv
hw/instCache.sv
hw/dataCache.sv
hw/axiReadMaster.sv
hw/axiWriteMaster.sv
hw/cacheTop.sv
verification/clockGen.sv
verification/axiMemModel.sv
verification/cacheTb.sv

//--- Makefile
TOP := cacheTb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  localparam int waitLimit = 400;
  localparam cachePkg::sizeT sizeByte = 2'd0;
  localparam cachePkg::sizeT sizeHalf = 2'd1;
  localparam cachePkg::sizeT sizeWord = 2'd2;

  typedef enum logic [1:0] {
    instRead,
    dataRead,
    dataWrite,
    bothRead
  } opKindT;

  // one row of the operation table
  typedef struct packed {
    opKindT         kind;
    cachePkg::sizeT size;
    cachePkg::addrT addr;
    cachePkg::addrT pairAddr;
    cachePkg::wordT wdata;
    logic [3:0]     arCount;
    logic [3:0]     awCount;
  } opT;

  logic clk;
  logic resetn;
  logic instReq;
  cachePkg::addrT instAddr;
  logic instAddrOk;
  logic instDataOk;
  cachePkg::wordT instRdata;
  logic dataReq;
  logic dataWr;
  cachePkg::sizeT dataSize;
  cachePkg::addrT dataAddr;
  cachePkg::wordT dataWdata;
  logic dataAddrOk;
  logic dataDataOk;
  cachePkg::wordT dataRdata;
  logic ARVALID;
  logic ARREADY;
  cachePkg::addrT ARADDR;
  cachePkg::burstLenT ARLEN;
  logic [1:0] ARBURST;
  logic RVALID;
  logic RREADY;
  cachePkg::wordT RDATA;
  logic RLAST;
  logic AWVALID;
  logic AWREADY;
  cachePkg::addrT AWADDR;
  logic WVALID;
  logic WREADY;
  cachePkg::wordT WDATA;
  cachePkg::strbT WSTRB;
  logic BVALID;
  logic BREADY;

  opT opTable [$];
  logic [31:0] shadow [logic [29:0]];
  logic [31:0] arAddrLog [$];
  logic [31:0] arLenLog [$];
  logic [31:0] arBurstLog [$];
  logic [31:0] awAddrLog [$];
  logic [31:0] wDataLog [$];
  logic [31:0] wStrbLog [$];
  int bCount = 0;

  clockGen clockGenInst (
    .clk(clk),
    .resetn(resetn)
  );

  cacheTop #(
    .refillWords(8)
  ) DUT (
    .clk(clk), .resetn(resetn),
    .instReq(instReq), .instAddr(instAddr), .instAddrOk(instAddrOk),
    .instDataOk(instDataOk), .instRdata(instRdata),
    .dataReq(dataReq), .dataWr(dataWr), .dataSize(dataSize), .dataAddr(dataAddr),
    .dataWdata(dataWdata), .dataAddrOk(dataAddrOk), .dataDataOk(dataDataOk),
    .dataRdata(dataRdata),
    .ARVALID(ARVALID), .ARREADY(ARREADY), .ARADDR(ARADDR), .ARLEN(ARLEN),
    .ARBURST(ARBURST), .RVALID(RVALID), .RREADY(RREADY), .RDATA(RDATA), .RLAST(RLAST),
    .AWVALID(AWVALID), .AWREADY(AWREADY), .AWADDR(AWADDR),
    .WVALID(WVALID), .WREADY(WREADY), .WDATA(WDATA), .WSTRB(WSTRB),
    .BVALID(BVALID), .BREADY(BREADY)
  );

  axiMemModel memModel (
    .clk(clk), .resetn(resetn),
    .ARVALID(ARVALID), .ARREADY(ARREADY), .ARADDR(ARADDR), .ARLEN(ARLEN),
    .RVALID(RVALID), .RREADY(RREADY), .RDATA(RDATA), .RLAST(RLAST),
    .AWVALID(AWVALID), .AWREADY(AWREADY), .AWADDR(AWADDR),
    .WVALID(WVALID), .WREADY(WREADY), .WDATA(WDATA), .WSTRB(WSTRB),
    .BVALID(BVALID), .BREADY(BREADY)
  );

  ////////////////////////////////////////////////////////////////////
  // bus monitors
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (resetn && ARVALID && ARREADY) begin
      arAddrLog.push_back(ARADDR);
      arLenLog.push_back(32'(ARLEN));
      arBurstLog.push_back(32'(ARBURST));
    end
    if (resetn && AWVALID && AWREADY) begin
      awAddrLog.push_back(AWADDR);
    end
    if (resetn && WVALID && WREADY) begin
      wDataLog.push_back(WDATA);
      wStrbLog.push_back(32'(WSTRB));
    end
    if (resetn && BVALID && BREADY) begin
      bCount <= bCount + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // shadow memory and expected values
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] shadowRead(input cachePkg::addrT byteAddr);
    logic [29:0] a;
    a = byteAddr[31:2];
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return {2'b00, a} ^ 32'hA5A5_0000;
  endfunction

  function automatic void shadowWrite(input cachePkg::addrT byteAddr, input cachePkg::wordT data,
                                      input cachePkg::strbT strb);
    logic [31:0] word;
    word = shadowRead(byteAddr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    shadow[byteAddr[31:2]] = word;
  endfunction

  // byte lanes touched by a store
  function automatic cachePkg::strbT laneMask(input cachePkg::sizeT size, input logic [1:0] offset);
    case (size)
      sizeByte: return 4'b0001 << offset;
      sizeHalf: return offset[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic stopOnFailure();
    $display("Test failed");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      stopOnFailure();
    end
  endtask

  task automatic checkBlockRead(input int idx, input cachePkg::addrT addr);
    checkValue("ARADDR", arAddrLog[idx], addr & 32'hFFFF_FFE0);
    checkValue("ARLEN", arLenLog[idx], 32'd7);
    checkValue("ARBURST", arBurstLog[idx], 32'd1);
  endtask

  task automatic checkWordRead(input int idx, input cachePkg::addrT addr);
    checkValue("ARADDR", arAddrLog[idx], addr & 32'hFFFF_FFFC);
    checkValue("ARLEN", arLenLog[idx], 32'd0);
    checkValue("ARBURST", arBurstLog[idx], 32'd0);
  endtask

  task automatic addOp(input opKindT kind, input cachePkg::sizeT size, input cachePkg::addrT addr,
                       input cachePkg::addrT pairAddr, input cachePkg::wordT wdata,
                       input int arCount, input int awCount);
    opT op;
    op.kind = kind;
    op.size = size;
    op.addr = addr;
    op.pairAddr = pairAddr;
    op.wdata = wdata;
    op.arCount = 4'(arCount);
    op.awCount = 4'(awCount);
    opTable.push_back(op);
  endtask

  task automatic buildTable();
    // instruction miss, then the rest of its block
    addOp(instRead,  sizeWord, 32'h0000_1048, '0, '0,            1, 0);
    addOp(instRead,  sizeWord, 32'h0000_1040, '0, '0,            0, 0);
    addOp(instRead,  sizeWord, 32'h0000_1044, '0, '0,            0, 0);
    addOp(instRead,  sizeWord, 32'h0000_104C, '0, '0,            0, 0);
    addOp(instRead,  sizeWord, 32'h0000_1050, '0, '0,            0, 0);
    addOp(instRead,  sizeWord, 32'h0000_1054, '0, '0,            0, 0);
    addOp(instRead,  sizeWord, 32'h0000_1058, '0, '0,            0, 0);
    addOp(instRead,  sizeWord, 32'h0000_105C, '0, '0,            0, 0);
    // data miss, then a hit
    addOp(dataRead,  sizeWord, 32'h2000_0100, '0, '0,            1, 0);
    addOp(dataRead,  sizeWord, 32'h2000_0100, '0, '0,            0, 0);
    // stores into a cached line, each read back as a hit
    addOp(dataWrite, sizeByte, 32'h2000_0101, '0, 32'h1234_5678, 0, 1);
    addOp(dataRead,  sizeWord, 32'h2000_0100, '0, '0,            0, 0);
    addOp(dataWrite, sizeByte, 32'h2000_0103, '0, 32'h9A00_0000, 0, 1);
    addOp(dataRead,  sizeWord, 32'h2000_0100, '0, '0,            0, 0);
    addOp(dataWrite, sizeHalf, 32'h2000_0102, '0, 32'hBEEF_0000, 0, 1);
    addOp(dataRead,  sizeWord, 32'h2000_0100, '0, '0,            0, 0);
    addOp(dataWrite, sizeHalf, 32'h2000_0100, '0, 32'h0000_C0DE, 0, 1);
    addOp(dataRead,  sizeWord, 32'h2000_0100, '0, '0,            0, 0);
    addOp(dataWrite, sizeWord, 32'h2000_0100, '0, 32'hCAFE_F00D, 0, 1);
    addOp(dataRead,  sizeWord, 32'h2000_0100, '0, '0,            0, 0);
    // no allocation on a write miss
    addOp(dataWrite, sizeHalf, 32'h2000_0302, '0, 32'h5A5A_0000, 0, 1);
    addOp(dataRead,  sizeWord, 32'h2000_0300, '0, '0,            1, 0);
    // both sides miss on the same edge
    addOp(bothRead,  sizeWord, 32'h2000_0400, 32'h0000_3004, '0, 2, 0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // core side driver
  ////////////////////////////////////////////////////////////////////

  task automatic runAccess(input logic useInst, input cachePkg::addrT iAddr, input logic useData,
                           input logic wr, input cachePkg::sizeT size,
                           input cachePkg::addrT dAddr, input cachePkg::wordT wdata,
                           output cachePkg::wordT iData, output cachePkg::wordT dData);
    logic instPending;
    logic dataPending;
    int cycles;
    iData = '0;
    dData = '0;
    @(posedge clk);
    if (useInst) begin
      instReq <= 1'b1;
      instAddr <= iAddr;
    end
    if (useData) begin
      dataReq <= 1'b1;
      dataWr <= wr;
      dataSize <= size;
      dataAddr <= dAddr;
      dataWdata <= wdata;
    end
    instPending = useInst;
    dataPending = useData;
    cycles = 0;
    while ((instPending || dataPending) && cycles < waitLimit) begin
      @(posedge clk);
      cycles++;
      if (instPending && instAddrOk) begin
        instPending = 1'b0;
        instReq <= 1'b0;
      end
      if (dataPending && dataAddrOk) begin
        dataPending = 1'b0;
        dataReq <= 1'b0;
      end
    end
    if (instPending || dataPending) begin
      $display("timeout: addrOk never came for the request at %0t ns", $time);
      stopOnFailure();
    end
    instPending = useInst;
    dataPending = useData;
    cycles = 0;
    while ((instPending || dataPending) && cycles < waitLimit) begin
      @(posedge clk);
      cycles++;
      if (instPending && instDataOk) begin
        instPending = 1'b0;
        iData = instRdata;
      end
      if (dataPending && dataDataOk) begin
        dataPending = 1'b0;
        dData = dataRdata;
      end
    end
    if (instPending || dataPending) begin
      $display("timeout: dataOk never came for the request at %0t ns", $time);
      stopOnFailure();
    end
  endtask

  task automatic waitWriteDone(input int target);
    int cycles;
    cycles = 0;
    while (bCount < target && cycles < waitLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (bCount < target) begin
      $display("timeout: the write response never completed at %0t ns", $time);
      stopOnFailure();
    end
  endtask

  initial begin
    opT op;
    cachePkg::wordT instGot;
    cachePkg::wordT dataGot;
    int arBase;
    int awBase;
    int bBase;
    int cycles;
    instReq <= 1'b0;
    instAddr <= '0;
    dataReq <= 1'b0;
    dataWr <= 1'b0;
    dataSize <= sizeWord;
    dataAddr <= '0;
    dataWdata <= '0;
    buildTable();
    cycles = 0;
    while (!resetn && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (!resetn) begin
      $display("timeout: reset was never released");
      stopOnFailure();
    end
    @(posedge clk);
    checkValue("instAddrOk", 32'(instAddrOk), 32'd0);
    checkValue("instDataOk", 32'(instDataOk), 32'd0);
    checkValue("dataAddrOk", 32'(dataAddrOk), 32'd0);
    checkValue("dataDataOk", 32'(dataDataOk), 32'd0);
    checkValue("ARVALID", 32'(ARVALID), 32'd0);
    checkValue("RREADY", 32'(RREADY), 32'd0);
    checkValue("AWVALID", 32'(AWVALID), 32'd0);
    checkValue("WVALID", 32'(WVALID), 32'd0);
    checkValue("BREADY", 32'(BREADY), 32'd0);

    for (int i = 0; i < opTable.size(); i++) begin
      op = opTable[i];
      arBase = arAddrLog.size();
      awBase = awAddrLog.size();
      bBase = bCount;
      case (op.kind)
        instRead: runAccess(1'b1, op.addr, 1'b0, 1'b0, sizeWord, '0, '0, instGot, dataGot);
        dataRead: runAccess(1'b0, '0, 1'b1, 1'b0, op.size, op.addr, '0, instGot, dataGot);
        dataWrite: runAccess(1'b0, '0, 1'b1, 1'b1, op.size, op.addr, op.wdata, instGot, dataGot);
        default: runAccess(1'b1, op.pairAddr, 1'b1, 1'b0, op.size, op.addr, '0, instGot, dataGot);
      endcase
      if (op.kind == dataWrite) begin
        waitWriteDone(bBase + 1);
        shadowWrite(op.addr, op.wdata, laneMask(op.size, op.addr[1:0]));
      end
      checkValue("AR handshakes", 32'(arAddrLog.size() - arBase), 32'(op.arCount));
      checkValue("AW handshakes", 32'(awAddrLog.size() - awBase), 32'(op.awCount));
      case (op.kind)
        instRead: begin
          checkValue("instRdata", instGot, shadowRead(op.addr));
          if (op.arCount != 0) begin
            checkBlockRead(arBase, op.addr);
          end
        end
        dataRead: begin
          checkValue("dataRdata", dataGot, shadowRead(op.addr));
          if (op.arCount != 0) begin
            checkWordRead(arBase, op.addr);
          end
        end
        dataWrite: begin
          checkValue("AWADDR", awAddrLog[awBase], op.addr);
          checkValue("WSTRB", wStrbLog[awBase], 32'(laneMask(op.size, op.addr[1:0])));
          checkValue("WDATA", wDataLog[awBase], op.wdata);
        end
        default: begin
          // data side wins the arbitration
          checkValue("dataRdata", dataGot, shadowRead(op.addr));
          checkValue("instRdata", instGot, shadowRead(op.pairAddr));
          checkWordRead(arBase, op.addr);
          checkBlockRead(arBase + 1, op.pairAddr);
        end
      endcase
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- verification/axiMemModel.sv
`timescale 1ns/1ps

module axiMemModel (
  input  logic               clk,
  input  logic               resetn,
  input  logic               ARVALID,
  output logic               ARREADY,
  input  cachePkg::addrT     ARADDR,
  input  cachePkg::burstLenT ARLEN,
  output logic               RVALID,
  input  logic               RREADY,
  output cachePkg::wordT     RDATA,
  output logic               RLAST,
  input  logic               AWVALID,
  output logic               AWREADY,
  input  cachePkg::addrT     AWADDR,
  input  logic               WVALID,
  output logic               WREADY,
  input  cachePkg::wordT     WDATA,
  input  cachePkg::strbT     WSTRB,
  output logic               BVALID,
  input  logic               BREADY
);

  // sparse word store, untouched words follow the fill rule
  logic [31:0] mem [logic [29:0]];
  integer seed = 1153;

  logic reading;
  logic haveAw;
  cachePkg::addrT rAddr;
  cachePkg::addrT wAddr;
  cachePkg::burstLenT rLeft;
  int arDelay;
  int rDelay;
  int awDelay;
  int wDelay;

  function automatic logic [31:0] fetchWord(input logic [31:0] byteAddr);
    logic [29:0] a;
    a = byteAddr[31:2];
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {2'b00, a} ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  // stall of 0 to 3 cycles
  function automatic int drawDelay();
    return $unsigned($random(seed)) % 4;
  endfunction

  always @(posedge clk) begin
    if (!resetn) begin
      ARREADY <= 1'b0;
      RVALID <= 1'b0;
      RLAST <= 1'b0;
      RDATA <= '0;
      AWREADY <= 1'b0;
      WREADY <= 1'b0;
      BVALID <= 1'b0;
      reading <= 1'b0;
      haveAw <= 1'b0;
      arDelay <= drawDelay();
      awDelay <= drawDelay();
      wDelay <= drawDelay();
      rDelay <= 0;
    end else begin
      //////////////////////////////////////////////////////////////////
      // read address and read data
      //////////////////////////////////////////////////////////////////
      if (ARVALID && ARREADY) begin
        ARREADY <= 1'b0;
        reading <= 1'b1;
        rAddr <= ARADDR;
        rLeft <= ARLEN;
        rDelay <= drawDelay();
        arDelay <= drawDelay();
      end else if (ARVALID && !reading) begin
        if (arDelay == 0) begin
          ARREADY <= 1'b1;
        end else begin
          arDelay <= arDelay - 1;
        end
      end
      if (reading) begin
        if (RVALID && RREADY) begin
          RVALID <= 1'b0;
          if (RLAST) begin
            reading <= 1'b0;
            RLAST <= 1'b0;
          end else begin
            // incrementing burst
            rAddr <= rAddr + 32'd4;
            rLeft <= rLeft - 8'd1;
            rDelay <= drawDelay();
          end
        end else if (!RVALID) begin
          if (rDelay == 0) begin
            RVALID <= 1'b1;
            RDATA <= fetchWord(rAddr);
            RLAST <= (rLeft == '0);
          end else begin
            rDelay <= rDelay - 1;
          end
        end
      end
      //////////////////////////////////////////////////////////////////
      // write address, write data and response
      //////////////////////////////////////////////////////////////////
      if (AWVALID && AWREADY) begin
        AWREADY <= 1'b0;
        haveAw <= 1'b1;
        wAddr <= AWADDR;
        awDelay <= drawDelay();
      end else if (AWVALID && !haveAw) begin
        if (awDelay == 0) begin
          AWREADY <= 1'b1;
        end else begin
          awDelay <= awDelay - 1;
        end
      end
      if (WVALID && WREADY) begin
        WREADY <= 1'b0;
        mem[wAddr[31:2]] = mergeLanes(fetchWord(wAddr), WDATA, WSTRB);
        BVALID <= 1'b1;
        wDelay <= drawDelay();
      end else if (WVALID && haveAw && !BVALID) begin
        if (wDelay == 0) begin
          WREADY <= 1'b1;
        end else begin
          wDelay <= wDelay - 1;
        end
      end
      if (BVALID && BREADY) begin
        BVALID <= 1'b0;
        haveAw <= 1'b0;
      end
    end
  end

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int halfPeriod = 20,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic resetn
);

  int count = 0;

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  // low for the first rising edges, then released on an edge
  always @(posedge clk) begin
    if (count < resetCycles) begin
      count <= count + 1;
    end
  end

  assign resetn = (count >= resetCycles);

endmodule

//--- hw/cacheTop.sv
`timescale 1ns/1ps

module cacheTop #(
  parameter int refillWords = 8
) (
  input  logic               clk,
  input  logic               resetn,
  // instruction port
  input  logic               instReq,
  input  cachePkg::addrT     instAddr,
  output logic               instAddrOk,
  output logic               instDataOk,
  output cachePkg::wordT     instRdata,
  // data port
  input  logic               dataReq,
  input  logic               dataWr,
  input  cachePkg::sizeT     dataSize,
  input  cachePkg::addrT     dataAddr,
  input  cachePkg::wordT     dataWdata,
  output logic               dataAddrOk,
  output logic               dataDataOk,
  output cachePkg::wordT     dataRdata,
  // AXI
  output logic               ARVALID,
  input  logic               ARREADY,
  output cachePkg::addrT     ARADDR,
  output cachePkg::burstLenT ARLEN,
  output logic [1:0]         ARBURST,
  input  logic               RVALID,
  output logic               RREADY,
  input  cachePkg::wordT     RDATA,
  input  logic               RLAST,
  output logic               AWVALID,
  input  logic               AWREADY,
  output cachePkg::addrT     AWADDR,
  output logic               WVALID,
  input  logic               WREADY,
  output cachePkg::wordT     WDATA,
  output cachePkg::strbT     WSTRB,
  input  logic               BVALID,
  output logic               BREADY
);

  cachePkg::readReqT instReadReq;
  cachePkg::readReqT dataReadReq;
  cachePkg::readBeatT instBeat;
  cachePkg::readBeatT dataBeat;
  cachePkg::writeReqT writeReq;
  logic writeBusy;

  instCache #(
    .refillWords(refillWords)
  ) instCacheInst (
    .clk(clk),
    .resetn(resetn),
    .req(instReq),
    .addr(instAddr),
    .readBeat(instBeat),
    .addrOk(instAddrOk),
    .dataOk(instDataOk),
    .rdata(instRdata),
    .readReq(instReadReq)
  );

  dataCache dataCacheInst (
    .clk(clk),
    .resetn(resetn),
    .req(dataReq),
    .wr(dataWr),
    .size(dataSize),
    .addr(dataAddr),
    .wdata(dataWdata),
    .readBeat(dataBeat),
    .writeBusy(writeBusy),
    .addrOk(dataAddrOk),
    .dataOk(dataDataOk),
    .rdata(dataRdata),
    .readReq(dataReadReq),
    .writeReq(writeReq)
  );

  axiReadMaster readMaster (
    .clk(clk),
    .resetn(resetn),
    .instReq(instReadReq),
    .dataReq(dataReadReq),
    .ARREADY(ARREADY),
    .RVALID(RVALID),
    .RLAST(RLAST),
    .RDATA(RDATA),
    .instBeat(instBeat),
    .dataBeat(dataBeat),
    .ARVALID(ARVALID),
    .RREADY(RREADY),
    .ARADDR(ARADDR),
    .ARLEN(ARLEN),
    .ARBURST(ARBURST)
  );

  axiWriteMaster writeMaster (
    .clk(clk),
    .resetn(resetn),
    .writeReq(writeReq),
    .AWREADY(AWREADY),
    .WREADY(WREADY),
    .BVALID(BVALID),
    .writeBusy(writeBusy),
    .AWVALID(AWVALID),
    .WVALID(WVALID),
    .BREADY(BREADY),
    .AWADDR(AWADDR),
    .WDATA(WDATA),
    .WSTRB(WSTRB)
  );

endmodule

//--- hw/axiWriteMaster.sv
`timescale 1ns/1ps

module axiWriteMaster (
  input  logic               clk,
  input  logic               resetn,
  input  cachePkg::writeReqT writeReq,
  input  logic               AWREADY,
  input  logic               WREADY,
  input  logic               BVALID,
  output logic               writeBusy,
  output logic               AWVALID,
  output logic               WVALID,
  output logic               BREADY,
  output cachePkg::addrT     AWADDR,
  output cachePkg::wordT     WDATA,
  output cachePkg::strbT     WSTRB
);

  typedef enum logic [1:0] {
    idle,
    addr,
    data,
    resp
  } stateT;

  stateT state;

  assign writeBusy = (state != idle);
  assign AWVALID = (state == addr);
  assign WVALID = (state == data);
  assign BREADY = (state == resp);

  // AW, then W, then B
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= idle;
    end else begin
      case (state)
        idle: if (writeReq.valid) state <= addr;
        addr: if (AWREADY) state <= data;
        data: if (WREADY) state <= resp;
        resp: if (BVALID) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && writeReq.valid) begin
      AWADDR <= writeReq.addr;
      WDATA <= writeReq.data;
      WSTRB <= writeReq.strb;
    end
  end

endmodule

//--- hw/axiReadMaster.sv
`timescale 1ns/1ps

module axiReadMaster (
  input  logic               clk,
  input  logic               resetn,
  input  cachePkg::readReqT  instReq,
  input  cachePkg::readReqT  dataReq,
  input  logic               ARREADY,
  input  logic               RVALID,
  input  logic               RLAST,
  input  cachePkg::wordT     RDATA,
  output cachePkg::readBeatT instBeat,
  output cachePkg::readBeatT dataBeat,
  output logic               ARVALID,
  output logic               RREADY,
  output cachePkg::addrT     ARADDR,
  output cachePkg::burstLenT ARLEN,
  output logic [1:0]         ARBURST
);

  typedef enum logic [1:0] {
    idle,
    addr,
    data,
    stall
  } stateT;

  stateT state;
  logic grantData;
  cachePkg::addrT addrReg;
  cachePkg::burstLenT lenReg;
  logic beatFire;

  assign ARVALID = (state == addr);
  assign ARADDR = addrReg;
  assign ARLEN = lenReg;
  // INCR for bursts, FIXED for single beats
  assign ARBURST = (lenReg != '0) ? 2'b01 : 2'b00;
  assign RREADY = (state == data);

  assign beatFire = (state == data) && RVALID;

  // beats go to the granted cache only
  assign instBeat.valid = beatFire && !grantData;
  assign instBeat.last = RLAST;
  assign instBeat.data = RDATA;
  assign dataBeat.valid = beatFire && grantData;
  assign dataBeat.last = RLAST;
  assign dataBeat.data = RDATA;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= idle;
      grantData <= 1'b0;
    end else begin
      case (state)
        idle: begin
          // data side has priority
          if (dataReq.valid) begin
            grantData <= 1'b1;
            state <= addr;
          end else if (instReq.valid) begin
            grantData <= 1'b0;
            state <= addr;
          end
        end
        addr: if (ARREADY) state <= data;
        data: if (RVALID && RLAST) state <= stall;
        stall: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle) begin
      addrReg <= dataReq.valid ? dataReq.addr : instReq.addr;
      lenReg <= dataReq.valid ? dataReq.len : instReq.len;
    end
  end

endmodule

//--- hw/dataCache.sv
`timescale 1ns/1ps

module dataCache (
  input  logic               clk,
  input  logic               resetn,
  input  logic               req,
  input  logic               wr,
  input  cachePkg::sizeT     size,
  input  cachePkg::addrT     addr,
  input  cachePkg::wordT     wdata,
  input  cachePkg::readBeatT readBeat,
  input  logic               writeBusy,
  output logic               addrOk,
  output logic               dataOk,
  output cachePkg::wordT     rdata,
  output cachePkg::readReqT  readReq,
  output cachePkg::writeReqT writeReq
);

  typedef enum logic [2:0] {
    idle,
    lookup,
    storeWait,
    missWait,
    fill
  } stateT;

  stateT state;
  logic wrReg;
  logic reqValid;
  cachePkg::addrT addrReg;
  cachePkg::sizeT sizeReg;
  cachePkg::wordT wdataReg;

  logic [1023:0] lineValid;
  cachePkg::tagT tagMem [1024];
  cachePkg::wordT dataMem [1024];

  cachePkg::tagT tag;
  cachePkg::indexT index;
  cachePkg::strbT strb;
  cachePkg::wordT merged;
  logic hit;
  logic storeFire;

  assign tag = addrReg[31:12];
  assign index = addrReg[11:2];
  assign hit = lineValid[index] && (tagMem[index] == tag);

  // lanes from size and offset
  always_comb begin
    case (sizeReg)
      2'd0: strb = 4'b0001 << addrReg[1:0];
      2'd1: strb = 4'b0011 << {addrReg[1], 1'b0};
      default: strb = 4'b1111;
    endcase
  end

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      merged[8*b +: 8] = strb[b] ? wdataReg[8*b +: 8] : dataMem[index][8*b +: 8];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // bus requests
  ////////////////////////////////////////////////////////////////////

  // store handed off only while the write master is free
  assign storeFire = (state == lookup || state == storeWait) && wrReg && !writeBusy;

  assign writeReq.valid = storeFire;
  assign writeReq.addr = addrReg;
  assign writeReq.data = wdataReg;
  assign writeReq.strb = strb;

  assign readReq.valid = reqValid;
  assign readReq.addr = {addrReg[31:2], 2'b00};
  assign readReq.len = '0;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= idle;
      wrReg <= 1'b0;
      addrOk <= 1'b0;
      dataOk <= 1'b0;
      reqValid <= 1'b0;
      lineValid <= '0;
    end else begin
      addrOk <= 1'b0;
      dataOk <= 1'b0;
      case (state)
        idle: begin
          if (req) begin
            wrReg <= wr;
            addrOk <= 1'b1;
            state <= lookup;
          end
        end
        lookup: begin
          if (wrReg) begin
            dataOk <= storeFire;
            state <= storeFire ? idle : storeWait;
          end else if (hit) begin
            dataOk <= 1'b1;
            state <= idle;
          end else if (!writeBusy) begin
            reqValid <= 1'b1;
            state <= fill;
          end else begin
            state <= missWait;
          end
        end
        storeWait: begin
          if (storeFire) begin
            dataOk <= 1'b1;
            state <= idle;
          end
        end
        missWait: begin
          // reads never pass a pending write
          if (!writeBusy) begin
            reqValid <= 1'b1;
            state <= fill;
          end
        end
        fill: begin
          if (readBeat.valid) begin
            reqValid <= 1'b0;
            if (readBeat.last) begin
              lineValid[index] <= 1'b1;
              dataOk <= 1'b1;
              state <= idle;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      addrReg <= addr;
      sizeReg <= size;
      wdataReg <= wdata;
    end
    if (state == lookup && hit) begin
      if (wrReg) begin
        dataMem[index] <= merged;
      end else begin
        rdata <= dataMem[index];
      end
    end
    if (state == fill && readBeat.valid && readBeat.last) begin
      dataMem[index] <= readBeat.data;
      tagMem[index] <= tag;
      rdata <= readBeat.data;
    end
  end

endmodule

//--- hw/instCache.sv
`timescale 1ns/1ps

module instCache #(
  parameter int refillWords = 8
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic               req,
  input  cachePkg::addrT     addr,
  input  cachePkg::readBeatT readBeat,
  output logic               addrOk,
  output logic               dataOk,
  output cachePkg::wordT     rdata,
  output cachePkg::readReqT  readReq
);

  localparam int cntW = (refillWords > 1) ? $clog2(refillWords) : 1;
  localparam cachePkg::indexT blockMask = cachePkg::indexT'(refillWords - 1);

  typedef enum logic [1:0] {
    idle,
    lookup,
    refill,
    update
  } stateT;

  stateT state;
  cachePkg::addrT addrReg;
  logic reqValid;
  logic [cntW-1:0] beatCnt;

  logic [1023:0] lineValid;
  cachePkg::tagT tagMem [1024];
  cachePkg::wordT dataMem [1024];
  cachePkg::wordT refillBuf [refillWords];

  cachePkg::tagT tag;
  cachePkg::indexT index;
  cachePkg::indexT blockBase;
  cachePkg::indexT wordSel;
  logic hit;

  assign tag = addrReg[31:12];
  assign index = addrReg[11:2];
  assign blockBase = index & ~blockMask;
  assign wordSel = index & blockMask;
  assign hit = lineValid[index] && (tagMem[index] == tag);

  // aligned block refill
  assign readReq.valid = reqValid;
  assign readReq.addr = {tag, blockBase, 2'b00};
  assign readReq.len = cachePkg::burstLenT'(refillWords - 1);

  ////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= idle;
      addrOk <= 1'b0;
      dataOk <= 1'b0;
      reqValid <= 1'b0;
      beatCnt <= '0;
      lineValid <= '0;
    end else begin
      addrOk <= 1'b0;
      dataOk <= 1'b0;
      case (state)
        idle: begin
          if (req) begin
            addrOk <= 1'b1;
            state <= lookup;
          end
        end
        lookup: begin
          if (hit) begin
            dataOk <= 1'b1;
            state <= idle;
          end else begin
            reqValid <= 1'b1;
            beatCnt <= '0;
            state <= refill;
          end
        end
        refill: begin
          if (readBeat.valid) begin
            // first beat ends the request
            reqValid <= 1'b0;
            beatCnt <= beatCnt + 1'b1;
            if (readBeat.last) begin
              state <= update;
            end
          end
        end
        update: begin
          for (int j = 0; j < refillWords; j++) begin
            lineValid[blockBase | cachePkg::indexT'(j)] <= 1'b1;
          end
          dataOk <= 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // arrays and data path
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == idle && req) begin
      addrReg <= addr;
    end
    if (state == lookup && hit) begin
      rdata <= dataMem[index];
    end
    if (state == refill && readBeat.valid) begin
      refillBuf[beatCnt] <= readBeat.data;
    end
    if (state == update) begin
      for (int j = 0; j < refillWords; j++) begin
        dataMem[blockBase | cachePkg::indexT'(j)] <= refillBuf[j];
        tagMem[blockBase | cachePkg::indexT'(j)] <= tag;
      end
      rdata <= refillBuf[wordSel[cntW-1:0]];
    end
  end

endmodule

//--- hw/cachePkg.sv
package cachePkg;

  ////////////////////////////////////////////////////////////////////
  // address and data widths
  ////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addrT;
  typedef logic [31:0] wordT;

  // address bits 31..12
  typedef logic [19:0] tagT;

  // address bits 11..2
  typedef logic [9:0] indexT;

  typedef logic [3:0] strbT;

  // 0 byte, 1 halfword, 2 word
  typedef logic [1:0] sizeT;

  // beats minus one
  typedef logic [7:0] burstLenT;

  ////////////////////////////////////////////////////////////////////
  // cache to bus master traffic
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic     valid;
    addrT     addr;
    burstLenT len;
  } readReqT;

  typedef struct packed {
    logic valid;
    logic last;
    wordT data;
  } readBeatT;

  typedef struct packed {
    logic valid;
    addrT addr;
    wordT data;
    strbT strb;
  } writeReqT;

endpackage
